//--- design/err_trk_pkg.sv
package err_trk_pkg;

	// lane organisation of the receiver
	localparam int LANES_PER_GROUP = 4;
	localparam int GROUPS          = 3;
	localparam int LANES           = LANES_PER_GROUP * GROUPS;
	localparam int ERR_BITS        = 8;

	// the 32 frames of capture memory hold 8 full snapshots
	localparam int ADDR_BITS       = 5;
	localparam int MEM_DEPTH       = 1 << ADDR_BITS;
	localparam int FRAMES_PER_SNAP = 4;
	localparam int FRAME_BITS      = 48;

	// debug port returns a frame in 32-bit pieces
	localparam int CHUNK_BITS      = 32;
	localparam int CHUNKS          = 2;

	typedef logic signed [ERR_BITS-1:0] err_t;

	// lane 0 sits in the lowest bits of every field
	typedef struct packed {
		err_t [LANES-1:0]       errors;
		logic [LANES-1:0]       prbs_flags;
		logic [LANES-1:0]       bitstream;
		logic [LANES-1:0][1:0]  sd_flags;
	} lane_snapshot_t;

	typedef logic [FRAME_BITS-1:0] frame_t;

	typedef struct packed {
		logic [ADDR_BITS-1:0]       addr;
		logic [$clog2(CHUNKS)-1:0]  chunk;
		logic                       read;
		logic                       enable;
	} dbg_req_t;

	typedef enum logic [1:0] {READY, STORE, DONE} tracker_state_t;

endpackage

//--- design/capture_fsm.sv
`timescale 1ns/1ps

module capture_fsm (
	input  logic clk,
	input  logic rstb,
	input  logic trigger,
	input  logic dbg_read,
	input  logic dbg_enable,
	input  logic at_mem_end,
	input  logic last_frame,
	output logic write_en,
	output logic frame_advance,
	output logic addr_clear,
	output logic load_snap,
	output logic done
);

	err_trk_pkg::tracker_state_t state;
	err_trk_pkg::tracker_state_t next_state;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state <= err_trk_pkg::READY;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			err_trk_pkg::READY: begin
				// a trigger wins over a read request seen in the same cycle
				if (trigger) begin
					next_state = err_trk_pkg::STORE;
				end else if (dbg_read) begin
					next_state = err_trk_pkg::DONE;
				end
			end
			err_trk_pkg::STORE: begin
				// the write at the top address freezes the memory
				if (at_mem_end) begin
					next_state = err_trk_pkg::DONE;
				end else if (last_frame) begin
					next_state = dbg_read ? err_trk_pkg::DONE : err_trk_pkg::READY;
				end
			end
			err_trk_pkg::DONE: begin
				if (dbg_enable) begin
					next_state = err_trk_pkg::READY;
				end
			end
			default: begin
				next_state = err_trk_pkg::READY;
			end
		endcase
	end

	// snapshot is taken on the edge that sees the trigger
	assign load_snap = (state == err_trk_pkg::READY) && trigger;

	// every STORE cycle writes one frame and then moves the counter on
	assign write_en      = (state == err_trk_pkg::STORE);
	assign frame_advance = write_en;

	// rearm restarts writing from address 0
	assign addr_clear = (state == err_trk_pkg::DONE) && dbg_enable;
	assign done       = (state == err_trk_pkg::DONE);

endmodule

//--- design/capture_addr_counter.sv
`timescale 1ns/1ps

module capture_addr_counter (
	input  logic                              clk,
	input  logic                              rstb,
	input  logic                              frame_advance,
	input  logic                              addr_clear,
	output logic [err_trk_pkg::ADDR_BITS-1:0] write_addr,
	output logic [1:0]                        frame_sel,
	output logic                              at_mem_end,
	output logic                              last_frame
);

	localparam logic [1:0] LAST_FRAME_IDX = 2'(err_trk_pkg::FRAMES_PER_SNAP - 1);
	localparam logic [err_trk_pkg::ADDR_BITS-1:0] LAST_ADDR =
		err_trk_pkg::ADDR_BITS'(err_trk_pkg::MEM_DEPTH - 1);

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			write_addr <= '0;
			frame_sel  <= '0;
		end else if (addr_clear) begin
			write_addr <= '0;
			frame_sel  <= '0;
		end else if (frame_advance) begin
			// address and frame index move in step with every write
			write_addr <= write_addr + 1'b1;
			if (last_frame) begin
				frame_sel <= '0;
			end else begin
				frame_sel <= frame_sel + 1'b1;
			end
		end
	end

	assign last_frame = (frame_sel == LAST_FRAME_IDX);

	// high while the next write goes to the final memory word
	assign at_mem_end = (write_addr == LAST_ADDR);

endmodule

//--- design/snapshot_packer.sv
`timescale 1ns/1ps

module snapshot_packer (
	input  logic                        clk,
	input  logic                        rstb,
	input  logic                        load_snap,
	input  err_trk_pkg::lane_snapshot_t snap,
	input  logic [1:0]                  frame_sel,
	output err_trk_pkg::frame_t         wr_frame
);

	err_trk_pkg::lane_snapshot_t snap_q;
	err_trk_pkg::frame_t         frames [err_trk_pkg::FRAMES_PER_SNAP];

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			snap_q <= '0;
		end else if (load_snap) begin
			snap_q <= snap;
		end
	end

	// each error frame carries one group and keeps its upper bits at zero
	always_comb begin
		for (int g = 0; g < err_trk_pkg::GROUPS; g++) begin
			frames[g] = '0;
			for (int l = 0; l < err_trk_pkg::LANES_PER_GROUP; l++) begin
				frames[g][l*err_trk_pkg::ERR_BITS +: err_trk_pkg::ERR_BITS] =
					snap_q.errors[g*err_trk_pkg::LANES_PER_GROUP + l];
			end
		end
		// the flag frame has prbs lowest, then the recovered bits, then the detector pairs
		frames[err_trk_pkg::GROUPS] = {snap_q.sd_flags, snap_q.bitstream, snap_q.prbs_flags};
	end

	assign wr_frame = frames[frame_sel];

endmodule

//--- design/capture_sram.sv
`timescale 1ns/1ps

module capture_sram (
	input  logic                              clk,
	input  logic                              write_en,
	input  logic [err_trk_pkg::ADDR_BITS-1:0] addr,
	input  err_trk_pkg::frame_t               wdata,
	output err_trk_pkg::frame_t               rdata
);

	err_trk_pkg::frame_t mem [err_trk_pkg::MEM_DEPTH];

	// the single port returns the old word on a write cycle
	always_ff @(posedge clk) begin
		if (write_en) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

//--- design/debug_readout.sv
`timescale 1ns/1ps

module debug_readout (
	input  logic                               clk,
	input  logic                               rstb,
	input  logic                               done,
	input  logic [err_trk_pkg::ADDR_BITS-1:0]  write_addr,
	input  err_trk_pkg::dbg_req_t              dbg_req,
	input  err_trk_pkg::frame_t                rdata,
	output logic [err_trk_pkg::ADDR_BITS-1:0]  mem_addr,
	output logic [err_trk_pkg::CHUNK_BITS-1:0] dbg_data
);

	localparam int PAD_BITS = err_trk_pkg::CHUNKS * err_trk_pkg::CHUNK_BITS
		- err_trk_pkg::FRAME_BITS;

	logic chunk_q;

	// the debug port only owns the memory once capture is frozen
	assign mem_addr = done ? dbg_req.addr : write_addr;

	// chunk select delayed by one cycle to line up with the read data
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			chunk_q <= 1'b0;
		end else begin
			chunk_q <= dbg_req.chunk;
		end
	end

	always_comb begin
		if (chunk_q) begin
			dbg_data = {rdata[err_trk_pkg::FRAME_BITS-1:err_trk_pkg::CHUNK_BITS], {PAD_BITS{1'b0}}};
		end else begin
			dbg_data = rdata[err_trk_pkg::CHUNK_BITS-1:0];
		end
	end

endmodule

//--- design/error_tracker_top.sv
`timescale 1ns/1ps

module error_tracker_top (
	input  logic                               clk,
	input  logic                               rstb,
	input  logic                               trigger,
	input  err_trk_pkg::lane_snapshot_t        snap,
	input  err_trk_pkg::dbg_req_t              dbg_req,
	output logic [err_trk_pkg::CHUNK_BITS-1:0] dbg_data,
	output logic                               capture_done
);

	logic                              write_en;
	logic                              frame_advance;
	logic                              addr_clear;
	logic                              load_snap;
	logic                              at_mem_end;
	logic                              last_frame;
	logic [err_trk_pkg::ADDR_BITS-1:0] write_addr;
	logic [err_trk_pkg::ADDR_BITS-1:0] mem_addr;
	logic [1:0]                        frame_sel;
	err_trk_pkg::frame_t               wr_frame;
	err_trk_pkg::frame_t               rd_frame;

	capture_fsm capture_fsm_i (
		.clk           (clk),
		.rstb          (rstb),
		.trigger       (trigger),
		.dbg_read      (dbg_req.read),
		.dbg_enable    (dbg_req.enable),
		.at_mem_end    (at_mem_end),
		.last_frame    (last_frame),
		.write_en      (write_en),
		.frame_advance (frame_advance),
		.addr_clear    (addr_clear),
		.load_snap     (load_snap),
		.done          (capture_done)
	);

	capture_addr_counter capture_addr_counter_i (
		.clk           (clk),
		.rstb          (rstb),
		.frame_advance (frame_advance),
		.addr_clear    (addr_clear),
		.write_addr    (write_addr),
		.frame_sel     (frame_sel),
		.at_mem_end    (at_mem_end),
		.last_frame    (last_frame)
	);

	snapshot_packer snapshot_packer_i (
		.clk       (clk),
		.rstb      (rstb),
		.load_snap (load_snap),
		.snap      (snap),
		.frame_sel (frame_sel),
		.wr_frame  (wr_frame)
	);

	capture_sram capture_sram_i (
		.clk      (clk),
		.write_en (write_en),
		.addr     (mem_addr),
		.wdata    (wr_frame),
		.rdata    (rd_frame)
	);

	debug_readout debug_readout_i (
		.clk        (clk),
		.rstb       (rstb),
		.done       (capture_done),
		.write_addr (write_addr),
		.dbg_req    (dbg_req),
		.rdata      (rd_frame),
		.mem_addr   (mem_addr),
		.dbg_data   (dbg_data)
	);

endmodule

//--- sim/error_tracker_tb.sv
`timescale 1ns/1ps

module error_tracker_tb;

	localparam int RECORDS        = 16;
	localparam int WORDS_PER_REC  = 7;
	localparam int TIMEOUT_CYCLES = RECORDS * 10 + 400;
	localparam int DRIVE_DELAY    = 2;

	logic                               clk;
	logic                               rstb;
	logic                               trigger;
	err_trk_pkg::lane_snapshot_t        snap;
	err_trk_pkg::dbg_req_t              dbg_req;
	logic [err_trk_pkg::CHUNK_BITS-1:0] dbg_data;
	logic                               capture_done;

	err_trk_pkg::frame_t               vec_mem [RECORDS*WORDS_PER_REC];
	err_trk_pkg::frame_t               exp_mem [err_trk_pkg::MEM_DEPTH];
	logic [err_trk_pkg::ADDR_BITS-1:0] exp_ptr;
	integer                            seed;
	int                                value_errors = 0;
	int                                other_errors = 0;
	int                                cycle_count  = 0;

	error_tracker_top error_tracker_top_i (
		.clk          (clk),
		.rstb         (rstb),
		.trigger      (trigger),
		.snap         (snap),
		.dbg_req      (dbg_req),
		.dbg_data     (dbg_data),
		.capture_done (capture_done)
	);

	always #20 clk = ~clk;

	// watchdog sized from the number of vector records
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d value mismatches, %0d other failures", value_errors,
				other_errors + 1);
			$display("** FAIL **");
			$finish;
		end
	end

	// chunk 1 carries frame bits 47:32 in its upper half
	function automatic logic [err_trk_pkg::CHUNK_BITS-1:0] expected_chunk(
		input err_trk_pkg::frame_t frame, input logic sel);
		return sel ? {frame[47:32], 16'h0000} : frame[31:0];
	endfunction

	task automatic check_chunk(input int addr, input int chunk,
		input logic [err_trk_pkg::CHUNK_BITS-1:0] got,
		input logic [err_trk_pkg::CHUNK_BITS-1:0] expected);
		if (got !== expected) begin
			value_errors++;
			$display("FAILED dbg_data (addr %0d chunk %0d): got %h expected %h",
				addr, chunk, got, expected);
		end
	endtask

	task automatic check_done(input logic got, input logic expected);
		if (got !== expected) begin
			value_errors++;
			$display("FAILED capture_done: got %h expected %h", got, expected);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) next_cycle();
	endtask

	task automatic drive_trigger(input int rec);
		int base;
		base = rec * WORDS_PER_REC;
		snap = {vec_mem[base], vec_mem[base+1], vec_mem[base+2]};
		trigger = 1'b1;
		next_cycle();
		trigger = 1'b0;
	endtask

	// an accepted snapshot lands in the next four addresses of the model
	task automatic start_capture(input int rec);
		drive_trigger(rec);
		for (int f = 0; f < err_trk_pkg::FRAMES_PER_SNAP; f++) begin
			exp_mem[exp_ptr] = vec_mem[rec*WORDS_PER_REC + 3 + f];
			exp_ptr++;
		end
	endtask

	task automatic capture(input int rec, input int gap);
		start_capture(rec);
		idle(gap - 1);
	endtask

	task automatic wait_for_done(input int limit);
		int waited;
		waited = 0;
		while (capture_done !== 1'b1 && waited < limit) begin
			next_cycle();
			waited++;
		end
		if (capture_done !== 1'b1) begin
			other_errors++;
			$display("capture_done did not rise within %0d cycles", limit);
		end
	endtask

	task automatic request_freeze();
		dbg_req.read = 1'b1;
		wait_for_done(8);
		dbg_req.read = 1'b0;
	endtask

	task automatic rearm();
		dbg_req.enable = 1'b1;
		next_cycle();
		dbg_req.enable = 1'b0;
		exp_ptr = '0;
		check_done(capture_done, 1'b0);
	endtask

	// the data for each chunk request shows up one edge later
	task automatic readback(input int first, input int last);
		for (int a = first; a <= last; a++) begin
			for (int c = 0; c < err_trk_pkg::CHUNKS; c++) begin
				dbg_req.addr = err_trk_pkg::ADDR_BITS'(a);
				dbg_req.chunk = 1'(c);
				next_cycle();
				check_chunk(a, c, dbg_data, expected_chunk(exp_mem[a], 1'(c)));
			end
		end
	endtask

	initial begin
		int gap;
		clk = 1'b0;
		rstb = 1'b0;
		trigger = 1'b0;
		snap = '0;
		dbg_req = '0;
		exp_ptr = '0;
		seed = 12;
		$readmemh("sim/error_tracker_vectors.txt", vec_mem);
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		rstb = 1'b1;
		check_done(capture_done, 1'b0);

		// three snapshots then a read request freezes the tracker
		for (int r = 0; r < 3; r++) begin
			capture(r, 6);
		end
		request_freeze();
		readback(0, 11);

		// done must rise once the memory fills with no read request
		rearm();
		for (int i = 0; i < 8; i++) begin
			start_capture(3 + i);
			if (i < 7) begin
				gap = 5 + ($unsigned($random(seed)) % 4);
				idle(gap - 1);
				check_done(capture_done, 1'b0);
			end
		end
		wait_for_done(8);
		readback(0, 31);

		// triggers while frozen must not touch the memory
		repeat (3) begin
			drive_trigger(15);
			idle(2);
		end
		check_done(capture_done, 1'b1);
		readback(0, 31);

		// rearm overwrites from address 0 and keeps the older frames above
		rearm();
		capture(11, 5);
		request_freeze();
		readback(0, 31);

		// a trigger two cycles after an accepted one is dropped
		rearm();
		start_capture(12);
		idle(1);
		drive_trigger(13);
		idle(2);
		capture(14, 5);
		request_freeze();
		readback(0, 31);

		$display("errors: %0d value mismatches, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- compile.f
design/err_trk_pkg.sv
design/capture_fsm.sv
design/capture_addr_counter.sv
design/snapshot_packer.sv
design/capture_sram.sv
design/debug_readout.sv
design/error_tracker_top.sv
sim/error_tracker_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module error_tracker_tb \
	-Mdir obj_dir -o error_tracker_sim

output=$(./obj_dir/error_tracker_sim)
echo "$output"

if grep -qxF '** PASS **' <<< "$output"; then
	exit 0
else
	exit 1
fi

//--- sim/error_tracker_vectors.txt
// columns: snap[143:96] snap[95:48] snap[47:0] frame0 frame1 frame2 frame3 (48-bit hex)
// snap is {errors lane 11..0, prbs_flags, bitstream, sd_flags}, one snapshot per line
817f00ff1234 56789abcdef0 a5c3e19b2d47 00009abcdef0 000012345678 0000817f00ff 9b2d473e1a5c
010203040506 0708090a0b0c fff000555555 0000090a0b0c 000005060708 000001020304 555555000fff
f1e2d3c4b5a6 9788796a5b4c 123456789abc 0000796a5b4c 0000b5a69788 0000f1e2d3c4 789abc456123
102030405060 708090a0b0c0 00100200300f 000090a0b0c0 000050607080 000010203040 00300f002001
fedcba987654 3210abcdef01 abcdef012345 0000abcdef01 000076543210 0000fedcba98 012345defabc
800180028003 800480058006 800001c00003 000080058006 000080038004 000080018002 c00003001800
aaaaaaaaaaaa 555555555555 0f0f0fa5a5a5 000055555555 0000aaaa5555 0000aaaaaaaa a5a5a5f0f0f0
0123456789ab cdef76543210 369258147147 000076543210 000089abcdef 000001234567 147147258369
7f7e7d7c7b7a 797877767574 e01c02b03a04 000077767574 00007b7a7978 00007f7e7d7c b03a04c02e01
d1a2b3c4e5f6 a7b8c9d0e1f2 7e51a96c3d2e 0000c9d0e1f2 0000e5f6a7b8 0000d1a2b3c4 6c3d2e1a97e5
112233445566 778899aabbcc fedcba987654 000099aabbcc 000055667788 000011223344 987654cbafed
c0c1c2c3c4c5 c6c7c8c9cacb 0aa0bb0cc0dd 0000c8c9cacb 0000c4c5c6c7 0000c0c1c2c3 0cc0dd0bb0aa
a1a2a3a4a5a6 a7a8a9aaabac 111222333444 0000a9aaabac 0000a5a6a7a8 0000a1a2a3a4 333444222111
eeeeeeeeeeee dddddddddddd ccc999bbb888 0000dddddddd 0000eeeedddd 0000eeeeeeee bbb888999ccc
b1b2b3b4b5b6 b7b8b9babbbc 5a5a5a3c3c3c 0000b9babbbc 0000b5b6b7b8 0000b1b2b3b4 3c3c3ca5a5a5
999999999999 888888888888 777666444444 000088888888 000099998888 000099999999 444444666777
